// File: fofb_pkg.sv
package fofb_pkg;

    ////////////////////////////////////////
    // sizes
    localparam int N_BPM      = 8;   // position errors per frame
    localparam int N_MODE     = 4;   // eigenmodes
    localparam int N_CORR     = 4;   // correctors
    localparam int ERR_W      = 16;
    localparam int COEF_W     = 16;
    localparam int DATA_W     = 32;
    localparam int PS_W       = 20;  // supply word

    localparam int BPM_IDX_W  = $clog2(N_BPM);
    localparam int MODE_IDX_W = $clog2(N_MODE);
    localparam int CORR_IDX_W = $clog2(N_CORR);

    // accumulator widths
    localparam int UT_ACC_W   = 40;  // 32 bit product plus growth over N_BPM
    localparam int V_ACC_W    = 48;

    ////////////////////////////////////////
    // fixed point scaling and limits
    localparam int UT_SHIFT   = 8;
    localparam int V_SHIFT    = 8;
    localparam int PS_LIMIT   = 520000;

    ////////////////////////////////////////
    // types
    typedef enum logic [1:0] {
        MAT_UT,
        MAT_VP,
        MAT_VI,
        MAT_VD
    } matrix_e;

    typedef enum logic [1:0] {
        SRC_PID,
        SRC_USER,
        SRC_ZERO
    } src_sel_e;

    // row is mode (Ut) or corrector (V), col is bpm (Ut) or mode (V)
    typedef struct packed {
        matrix_e                  matrix;
        logic [3:0]               row;
        logic [3:0]               col;
        logic signed [COEF_W-1:0] data;
    } coef_wr_t;

    typedef struct packed {
        logic signed [DATA_W-1:0] sum;
        logic signed [DATA_W-1:0] integ;
        logic signed [DATA_W-1:0] delta;
    } mode_val_t;

    typedef mode_val_t [N_MODE-1:0] mode_vec_t;

    typedef logic [N_MODE-1:0][N_BPM-1:0][COEF_W-1:0]  ut_mat_t;
    typedef logic [N_CORR-1:0][N_MODE-1:0][COEF_W-1:0] v_mat_t;

    typedef struct packed {
        v_mat_t p;
        v_mat_t i;
        v_mat_t d;
    } v_set_t;

    typedef logic [N_CORR-1:0][DATA_W-1:0] corr_vec_t;
    typedef logic [N_CORR-1:0][PS_W-1:0]   ps_vec_t;

endpackage

// File: coef_decode.sv
`timescale 1ns/1ps

module coef_decode
    import fofb_pkg::*;
(
    input  logic                     sysClk,
    input  logic                     reset,
    input  coef_wr_t                 coef_wr_i,
    input  logic                     coef_wr_en_i,
    input  coef_wr_t                 coef_rd_i,
    output logic signed [COEF_W-1:0] coef_rd_data_o,
    output ut_mat_t                  ut_mat_o,
    output v_set_t                   v_set_o
);

    ut_mat_t                  ut_q;
    v_set_t                   v_q;
    logic signed [COEF_W-1:0] rd_data_q;

    // address check against the selected matrix shape
    function automatic logic in_range(coef_wr_t a);
        if (a.matrix == MAT_UT) begin
            in_range = (a.row < N_MODE) && (a.col < N_BPM);
        end else begin
            in_range = (a.row < N_CORR) && (a.col < N_MODE);
        end
    endfunction

    ////////////////////////////////////////
    // coefficient stores
    always_ff @(posedge sysClk) begin
        if (reset) begin
            ut_q <= '0;
            v_q  <= '0;
        end else if (coef_wr_en_i && in_range(coef_wr_i)) begin
            case (coef_wr_i.matrix)
                MAT_UT: ut_q[coef_wr_i.row[MODE_IDX_W-1:0]][coef_wr_i.col[BPM_IDX_W-1:0]]
                            <= coef_wr_i.data;
                MAT_VP: v_q.p[coef_wr_i.row[CORR_IDX_W-1:0]][coef_wr_i.col[MODE_IDX_W-1:0]]
                            <= coef_wr_i.data;
                MAT_VI: v_q.i[coef_wr_i.row[CORR_IDX_W-1:0]][coef_wr_i.col[MODE_IDX_W-1:0]]
                            <= coef_wr_i.data;
                default: v_q.d[coef_wr_i.row[CORR_IDX_W-1:0]][coef_wr_i.col[MODE_IDX_W-1:0]]
                            <= coef_wr_i.data;
            endcase
        end
    end

    // readback, one cycle latency
    always_ff @(posedge sysClk) begin
        if (!in_range(coef_rd_i)) begin
            rd_data_q <= '0; // outside the matrix reads zero
        end else begin
            case (coef_rd_i.matrix)
                MAT_UT: rd_data_q <= ut_q[coef_rd_i.row[MODE_IDX_W-1:0]]
                                         [coef_rd_i.col[BPM_IDX_W-1:0]];
                MAT_VP: rd_data_q <= v_q.p[coef_rd_i.row[CORR_IDX_W-1:0]]
                                          [coef_rd_i.col[MODE_IDX_W-1:0]];
                MAT_VI: rd_data_q <= v_q.i[coef_rd_i.row[CORR_IDX_W-1:0]]
                                          [coef_rd_i.col[MODE_IDX_W-1:0]];
                default: rd_data_q <= v_q.d[coef_rd_i.row[CORR_IDX_W-1:0]]
                                           [coef_rd_i.col[MODE_IDX_W-1:0]];
            endcase
        end
    end

    assign coef_rd_data_o = rd_data_q;
    assign ut_mat_o       = ut_q;
    assign v_set_o        = v_q;

    a_wr_in_range: assert property (@(posedge sysClk) disable iff (reset)
        coef_wr_en_i |-> in_range(coef_wr_i))
        else $error("coefficient write outside matrix %0d", coef_wr_i.matrix);

endmodule

// File: ut_mac.sv
`timescale 1ns/1ps

module ut_mac
    import fofb_pkg::*;
(
    input  logic                    sysClk,
    input  logic                    reset,
    input  logic signed [ERR_W-1:0] err_i,
    input  logic                    err_valid_i,
    input  logic                    err_last_i,
    input  ut_mat_t                 ut_mat_i,
    output mode_vec_t               modes_o,
    output logic                    modes_valid_o
);

    logic [BPM_IDX_W-1:0]       idx;          // sample index = Ut column
    logic signed [UT_ACC_W-1:0] acc [N_MODE];
    logic signed [UT_ACC_W-1:0] acc_next [N_MODE];
    logic signed [DATA_W-1:0]   sum_new [N_MODE];
    mode_vec_t                  modes_q;
    logic                       valid_q;

    ////////////////////////////////////////
    // projection onto each mode
    always_comb begin
        for (int m = 0; m < N_MODE; m++) begin
            acc_next[m] = acc[m] + $signed(ut_mat_i[m][idx]) * err_i;
            sum_new[m]  = DATA_W'(acc_next[m] >>> UT_SHIFT);
        end
    end

    always_ff @(posedge sysClk) begin
        if (reset) begin
            idx     <= '0;
            valid_q <= 1'b0;
            modes_q <= '0; // integrals and previous sums start at zero
            for (int m = 0; m < N_MODE; m++) begin
                acc[m] <= '0;
            end
        end else begin
            valid_q <= 1'b0;
            if (err_valid_i) begin
                if (err_last_i) begin
                    idx     <= '0;
                    valid_q <= 1'b1;
                    for (int m = 0; m < N_MODE; m++) begin
                        acc[m]           <= '0;
                        modes_q[m].sum   <= sum_new[m];
                        modes_q[m].integ <= modes_q[m].integ + sum_new[m]; // wraps
                        modes_q[m].delta <= sum_new[m] - modes_q[m].sum;
                    end
                end else begin
                    idx <= idx + 1'b1;
                    for (int m = 0; m < N_MODE; m++) begin
                        acc[m] <= acc_next[m];
                    end
                end
            end
        end
    end

    assign modes_o       = modes_q;
    assign modes_valid_o = valid_q;

    // frame length check
    a_last_at_end: assert property (@(posedge sysClk) disable iff (reset)
        err_valid_i |-> (err_last_i == (idx == BPM_IDX_W'(N_BPM - 1))))
        else $error("err_last_i not on sample %0d (index %0d)", N_BPM - 1, idx);

endmodule

// File: v_mac.sv
`timescale 1ns/1ps

module v_mac
    import fofb_pkg::*;
(
    input  logic      sysClk,
    input  logic      reset,
    input  mode_vec_t modes_i,
    input  logic      modes_valid_i,
    input  v_set_t    v_set_i,
    output corr_vec_t corr_o,
    output logic      corr_valid_o
);

    typedef enum logic {
        IDLE,
        ACCUM
    } state_e;

    state_e                    state;
    logic [MODE_IDX_W-1:0]     idx;
    logic                      last_mode;
    mode_val_t                 mv;
    logic signed [V_ACC_W-1:0] acc [N_CORR];
    logic signed [V_ACC_W-1:0] acc_next [N_CORR];
    corr_vec_t                 corr_q;
    logic                      valid_q;

    assign last_mode = (idx == MODE_IDX_W'(N_MODE - 1));

    ////////////////////////////////////////
    // P+I+D terms of one mode, all correctors at once
    always_comb begin
        mv = modes_i[idx];
        for (int c = 0; c < N_CORR; c++) begin
            acc_next[c] = acc[c]
                        + $signed(v_set_i.p[c][idx]) * mv.sum
                        + $signed(v_set_i.i[c][idx]) * mv.integ
                        + $signed(v_set_i.d[c][idx]) * mv.delta;
        end
    end

    // mode stepping
    always_ff @(posedge sysClk) begin
        if (reset) begin
            state   <= IDLE;
            idx     <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state)
                IDLE: begin
                    idx <= '0;
                    if (modes_valid_i) state <= ACCUM;
                end
                ACCUM: begin
                    idx <= idx + 1'b1;
                    if (last_mode) begin
                        idx     <= '0;
                        valid_q <= 1'b1;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // accumulators and result
    always_ff @(posedge sysClk) begin
        for (int c = 0; c < N_CORR; c++) begin
            if (state == IDLE) begin
                acc[c] <= '0;
            end else begin
                acc[c] <= acc_next[c];
                if (last_mode) corr_q[c] <= DATA_W'(acc_next[c] >>> V_SHIFT); // truncate
            end
        end
    end

    assign corr_o       = corr_q;
    assign corr_valid_o = valid_q;

    // frames closer than N_MODE+1 cycles would corrupt the running sum
    a_no_overrun: assert property (@(posedge sysClk) disable iff (reset)
        modes_valid_i |-> state == IDLE)
        else $error("modes_valid_i while V stage busy");

endmodule

// File: corr_result.sv
`timescale 1ns/1ps

module corr_result
    import fofb_pkg::*;
(
    input  logic                     sysClk,
    input  logic                     reset,
    input  corr_vec_t                corr_i,
    input  logic                     corr_valid_i,
    input  src_sel_e                 src_sel_i,
    input  logic signed [DATA_W-1:0] user_set_i,
    input  logic                     test_mode_i,
    input  ps_vec_t                  test_ps_i,
    output ps_vec_t                  ps_o,
    output logic                     ps_valid_o
);

    logic signed [DATA_W-1:0] src_val [N_CORR];
    logic signed [DATA_W-1:0] lim_val [N_CORR];
    logic                     lim_ok;
    ps_vec_t                  ps_word;
    ps_vec_t                  ps_q;
    logic                     valid_q;

    ////////////////////////////////////////
    // source select, limit, offset binary
    always_comb begin
        int word_val; // supply word decoded back to a signed value
        lim_ok = 1'b1;
        for (int c = 0; c < N_CORR; c++) begin
            case (src_sel_i)
                SRC_PID:  src_val[c] = $signed(corr_i[c]);
                SRC_USER: src_val[c] = user_set_i;
                default:  src_val[c] = '0; // SRC_ZERO and the unused code
            endcase

            if (src_val[c] > PS_LIMIT) begin
                lim_val[c] = DATA_W'(PS_LIMIT);
            end else if (src_val[c] < -PS_LIMIT) begin
                lim_val[c] = DATA_W'(-PS_LIMIT);
            end else begin
                lim_val[c] = src_val[c];
            end

            ps_word[c] = {~lim_val[c][PS_W-1], lim_val[c][PS_W-2:0]}; // flip sign bit

            word_val = int'(ps_word[c]) - (1 << (PS_W - 1));
            lim_ok   = lim_ok && (word_val <= PS_LIMIT) && (word_val >= -PS_LIMIT);
        end
    end

    always_ff @(posedge sysClk) begin
        if (reset) begin
            ps_q    <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= corr_valid_i;
            if (corr_valid_i) ps_q <= test_mode_i ? test_ps_i : ps_word;
        end
    end

    assign ps_o       = ps_q;
    assign ps_valid_o = valid_q;

    a_limit: assert property (@(posedge sysClk) disable iff (reset)
        corr_valid_i |-> lim_ok)
        else $error("limited corrector value outside +/-%0d", PS_LIMIT);

endmodule

// File: fofb_top.sv
`timescale 1ns/1ps

module fofb_top
    import fofb_pkg::*;
(
    input  logic                     sysClk,
    input  logic                     reset,
    // coefficient access
    input  coef_wr_t                 coef_wr_i,
    input  logic                     coef_wr_en_i,
    input  coef_wr_t                 coef_rd_i,
    output logic signed [COEF_W-1:0] coef_rd_data_o,
    // error stream
    input  logic signed [ERR_W-1:0]  err_i,
    input  logic                     err_valid_i,
    input  logic                     err_last_i,
    // output control
    input  src_sel_e                 src_sel_i,
    input  logic signed [DATA_W-1:0] user_set_i,
    input  logic                     test_mode_i,
    input  ps_vec_t                  test_ps_i,
    // results
    output mode_vec_t                modes_o,
    output logic                     modes_valid_o,
    output ps_vec_t                  ps_o,
    output logic                     ps_valid_o
);

    ut_mat_t   ut_mat;
    v_set_t    v_set;
    corr_vec_t corr;
    logic      corr_valid;

    ////////////////////////////////////////
    coef_decode u_coef_decode (
        .sysClk         (sysClk),
        .reset          (reset),
        .coef_wr_i      (coef_wr_i),
        .coef_wr_en_i   (coef_wr_en_i),
        .coef_rd_i      (coef_rd_i),
        .coef_rd_data_o (coef_rd_data_o),
        .ut_mat_o       (ut_mat),
        .v_set_o        (v_set)
    );

    ut_mac u_ut_mac (
        .sysClk        (sysClk),
        .reset         (reset),
        .err_i         (err_i),
        .err_valid_i   (err_valid_i),
        .err_last_i    (err_last_i),
        .ut_mat_i      (ut_mat),
        .modes_o       (modes_o),       // also feeds the V stage
        .modes_valid_o (modes_valid_o)
    );

    v_mac u_v_mac (
        .sysClk        (sysClk),
        .reset         (reset),
        .modes_i       (modes_o),
        .modes_valid_i (modes_valid_o),
        .v_set_i       (v_set),
        .corr_o        (corr),
        .corr_valid_o  (corr_valid)
    );

    corr_result u_corr_result (
        .sysClk       (sysClk),
        .reset        (reset),
        .corr_i       (corr),
        .corr_valid_i (corr_valid),
        .src_sel_i    (src_sel_i),
        .user_set_i   (user_set_i),
        .test_mode_i  (test_mode_i),
        .test_ps_i    (test_ps_i),
        .ps_o         (ps_o),
        .ps_valid_o   (ps_valid_o)
    );

endmodule

// File: tb_fofb.sv
`timescale 1ns/1ps

module tb_fofb
    import fofb_pkg::*;
();

    localparam int TIMEOUT   = 50;         // cycles per wait
    localparam int MODES_LAT = 1;
    localparam int PS_LAT    = N_MODE + 3;

    logic                     sysClk;
    logic                     reset;
    coef_wr_t                 coef_wr_i;
    logic                     coef_wr_en_i;
    coef_wr_t                 coef_rd_i;
    logic signed [COEF_W-1:0] coef_rd_data_o;
    logic signed [ERR_W-1:0]  err_i;
    logic                     err_valid_i;
    logic                     err_last_i;
    src_sel_e                 src_sel_i;
    logic signed [DATA_W-1:0] user_set_i;
    logic                     test_mode_i;
    ps_vec_t                  test_ps_i;
    mode_vec_t                modes_o;
    logic                     modes_valid_o;
    ps_vec_t                  ps_o;
    logic                     ps_valid_o;

    int        coef_errs;
    int        mode_errs;
    int        ps_errs;
    int        lat_errs;
    int        other_errs;
    mode_vec_t got_modes;   // captured on the valid pulses
    ps_vec_t   got_ps;
    int        modes_lat;
    int        ps_lat;
    int        frame_no;
    logic      timed_out;
    int        fd;
    int        code;
    int        seed;
    string     kw;
    string     rest;
    int        a;
    int        b;
    int        c;
    int        d;
    int        vals [3*N_MODE];
    int        errs [N_BPM];
    mode_vec_t exp_modes;
    ps_vec_t   exp_ps;
    ps_vec_t   set_ps;
    logic      done;

    fofb_top UUT (.*);

    always #20 sysClk = ~sysClk;

    ////////////////////////////////////////
    // compare tasks
    task automatic check_coef(input logic signed [COEF_W-1:0] got,
                              input logic signed [COEF_W-1:0] exp, input string what);
        if (got !== exp) begin
            coef_errs++;
            $display("CHECK FAILED at %0t: readback %s got %04h expected %04h",
                     $time, what, got, exp);
        end
    endtask

    task automatic check_modes(input mode_vec_t got, input mode_vec_t exp);
        for (int m = 0; m < N_MODE; m++) begin
            if (got[m] !== exp[m]) begin
                mode_errs++;
                $display("CHECK FAILED at %0t: frame %0d mode %0d got %0d/%0d/%0d",
                         $time, frame_no, m, got[m].sum, got[m].integ, got[m].delta);
                $display("    expected sum/integ/delta %0d/%0d/%0d",
                         exp[m].sum, exp[m].integ, exp[m].delta);
            end
        end
    endtask

    task automatic check_ps(input ps_vec_t got, input ps_vec_t exp);
        for (int k = 0; k < N_CORR; k++) begin
            if (got[k] !== exp[k]) begin
                ps_errs++;
                $display("CHECK FAILED at %0t: frame %0d corrector %0d word %05h expected %05h",
                         $time, frame_no, k, got[k], exp[k]);
            end
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            lat_errs++;
            $display("CHECK FAILED at %0t: frame %0d %s after %0d cycles, expected %0d",
                     $time, frame_no, what, got, exp);
        end
    endtask

    ////////////////////////////////////////
    // bus and stream drivers
    task automatic write_coef(input int mat, input int row, input int col, input int data);
        @(negedge sysClk);
        coef_wr_i    = '{matrix: matrix_e'(mat), row: 4'(row), col: 4'(col),
                         data: COEF_W'(data)};
        coef_wr_en_i = 1'b1;
        @(negedge sysClk);
        coef_wr_en_i = 1'b0;
    endtask

    task automatic read_coef(input int mat, input int row, input int col, input int exp);
        @(negedge sysClk);
        coef_rd_i = '{matrix: matrix_e'(mat), row: 4'(row), col: 4'(col), data: '0};
        @(negedge sysClk); // one cycle readback latency
        check_coef(coef_rd_data_o, COEF_W'(exp),
                   $sformatf("matrix %0d [%0d][%0d]", mat, row, col));
    endtask

    // streams errs[] with random gaps, then waits for both result pulses
    task automatic run_frame();
        int gap;
        int cnt;
        for (int k = 0; k < N_BPM; k++) begin
            gap = $urandom % 4;
            repeat (gap) begin
                @(negedge sysClk);
                err_valid_i = 1'b0;
                err_last_i  = 1'b0;
            end
            @(negedge sysClk);
            err_i       = ERR_W'(errs[k]);
            err_valid_i = 1'b1;
            err_last_i  = (k == N_BPM - 1);
        end
        cnt       = 0;
        modes_lat = -1;
        ps_lat    = -1;
        while (ps_lat < 0 && cnt < TIMEOUT) begin
            @(negedge sysClk);
            err_valid_i = 1'b0;
            err_last_i  = 1'b0;
            cnt++;
            if (modes_valid_o && modes_lat < 0) begin
                modes_lat = cnt;
                got_modes = modes_o;
            end
            if (ps_valid_o) begin
                ps_lat = cnt;
                got_ps = ps_o;
            end
        end
        if (modes_lat < 0 || ps_lat < 0) begin
            other_errs++;
            timed_out = 1'b1;
            $display("timeout: frame %0d gave no result pulse within %0d cycles",
                     frame_no, TIMEOUT);
        end else begin
            check_latency(modes_lat, MODES_LAT, "modes_valid_o");
            check_latency(ps_lat, PS_LAT, "ps_valid_o");
        end
    endtask

    ////////////////////////////////////////
    initial begin
        sysClk       = 1'b0;
        reset        = 1'b1;
        coef_wr_i    = '0;
        coef_wr_en_i = 1'b0;
        coef_rd_i    = '0;
        err_i        = '0;
        err_valid_i  = 1'b0;
        err_last_i   = 1'b0;
        src_sel_i    = SRC_PID;
        user_set_i   = '0;
        test_mode_i  = 1'b0;
        test_ps_i    = '0;
        coef_errs    = 0;
        mode_errs    = 0;
        ps_errs      = 0;
        lat_errs     = 0;
        other_errs   = 0;
        frame_no     = 0;
        timed_out    = 1'b0;
        done         = 1'b0;
        seed         = $urandom(40);
        repeat (3) @(negedge sysClk);
        reset = 1'b0;

        fd = $fopen("fofb_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file fofb_tests.txt");
            other_errs++;
            done = 1'b1;
        end
        while (!done) begin
            code = $fscanf(fd, "%s", kw);
            if (code != 1) begin
                done = 1'b1; // end of file
            end else if (kw == "#") begin
                code = $fgets(rest, fd);
            end else if (kw == "W") begin
                code = $fscanf(fd, "%d %d %d %h", a, b, c, d);
                write_coef(a, b, c, d);
            end else if (kw == "R") begin
                code = $fscanf(fd, "%d %d %d %h", a, b, c, d);
                read_coef(a, b, c, d);
            end else if (kw == "S") begin
                code = $fscanf(fd, "%d %d %d", a, b, c);
                for (int k = 0; k < N_CORR; k++) begin
                    code      = $fscanf(fd, "%h", d);
                    set_ps[k] = PS_W'(d);
                end
                @(negedge sysClk);
                src_sel_i   = src_sel_e'(a);
                user_set_i  = b;
                test_mode_i = c[0];
                test_ps_i   = set_ps;
            end else if (kw == "F") begin
                for (int k = 0; k < N_BPM; k++) begin
                    code = $fscanf(fd, "%d", errs[k]);
                end
                frame_no++;
                run_frame();
                if (timed_out) done = 1'b1;
            end else if (kw == "M") begin
                for (int k = 0; k < 3*N_MODE; k++) begin
                    code = $fscanf(fd, "%d", vals[k]);
                end
                for (int m = 0; m < N_MODE; m++) begin
                    exp_modes[m].sum   = vals[3*m];
                    exp_modes[m].integ = vals[3*m+1];
                    exp_modes[m].delta = vals[3*m+2];
                end
                check_modes(got_modes, exp_modes);
            end else if (kw == "P") begin
                for (int k = 0; k < N_CORR; k++) begin
                    code      = $fscanf(fd, "%h", d);
                    exp_ps[k] = PS_W'(d);
                end
                check_ps(got_ps, exp_ps);
            end else begin
                $display("unknown line kind %s in the test data file", kw);
                other_errs++;
                done = 1'b1;
            end
        end
        if (fd != 0) $fclose(fd);

        $display("errors: coef %0d, modes %0d, ps %0d, latency %0d, other %0d",
                 coef_errs, mode_errs, ps_errs, lat_errs, other_errs);
        if (coef_errs + mode_errs + ps_errs + lat_errs + other_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: fofb_tests.txt
# W mat row col coef | R mat row col expect   (mat 0 Ut, 1 Vp, 2 Vi, 3 Vd; coef in hex)
# S src user test ps0..ps3 | F err0..err7 | M sum integ delta per mode | P ps0..ps3 in hex
W 0 0 0 0100
W 0 0 1 0100
W 0 1 2 0200
W 0 2 7 ff00
W 0 3 3 0080
W 1 0 0 2000
W 2 1 1 2000
W 3 2 2 0100
W 1 3 3 0200
W 2 3 0 0080
R 0 0 1 0100
R 0 2 7 ff00
R 1 0 0 2000
R 2 3 0 0080
R 3 2 2 0100
R 0 1 5 0000
# pid path, first delta measured from zero
S 0 0 0 00000 00000 00000 00000
F 1000 200 -300 -5 7 0 0 400
M 1200 1200 1200 -600 -600 -600 -400 -400 -400 -3 -3 -3
P 89600 7b500 7fe70 80252
F 500 -100 100 9 0 0 0 -200
M 400 1600 -800 200 -400 800 200 -200 600 4 1 7
P 83200 7ce00 80258 80328
# large errors drive correctors 0 and 1 into the limit
F 10000 10000 -10000 0 0 0 0 0
M 20000 21600 19600 -20000 -20400 -20200 0 -200 -200 0 1 -4
P fef40 010c0 7ff38 82a30
# user setpoint on all correctors
S 1 -123456 0 00000 00000 00000 00000
F 0 0 0 0 0 0 0 0
M 0 21600 -20000 0 -20400 20000 0 -200 0 0 1 0
P 61dc0 61dc0 61dc0 61dc0
# forced zero
S 2 0 0 00000 00000 00000 00000
F 0 0 0 0 0 0 0 0
M 0 21600 0 0 -20400 0 0 -200 0 0 1 0
P 80000 80000 80000 80000
# test mode overrides the pid words
S 0 0 1 12345 abcde 00001 fffff
F 10000 10000 0 0 0 0 0 0
M 20000 41600 20000 0 -20400 0 0 -200 0 0 1 0
P 12345 abcde 00001 fffff

// File: list.f
fofb_pkg.sv
coef_decode.sv
ut_mac.sv
v_mac.sv
corr_result.sv
fofb_top.sv
tb_fofb.sv

// File: Makefile
# Verilator build and run for the orbit feedback testbench

TOP       ?= tb_fofb
SIM_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat list.f)
BIN  := $(SIM_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): list.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(SIM_DIR) -f list.f

run: compile
	./$(BIN) | tee $(LOG)
	@if grep -q "All tests passed" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(SIM_DIR) $(LOG)
